// ==== include/bp_consts.svh ====
// ******************************
// Widths and depths shared by the front end.
// Queue depths are powers of two, given as log2.
// ******************************
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// Address and immediate width.
`define BP_XLEN 64

// Prediction queue, 16 entries.
`define BP_BHT_AW 4

// Return stack and return-pending count, 16 entries.
`define BP_RAS_AW 4

// APB byte offsets of the statistics block.
`define BP_REG_BRANCH  4'h0
`define BP_REG_MISPRED 4'h4
`define BP_REG_STALL   4'h8
`define BP_REG_CTRL    4'hC

`endif

// ==== source/bp_inst_pkg.sv ====
// ******************************
// Instruction-side types.
// Only 32-bit encodings are recognized.
// ******************************
package bp_inst_pkg;

	// ******************************
	// Major opcodes
	// ******************************

	// RV major opcodes, bits [6:0].
	// All three control opcodes end in 2'b11,
	// so RVC words fall to op_other.
	typedef enum logic [6:0] {
		op_other  = 7'b0000000, // Anything else.
		op_branch = 7'b1100011, // BEQ, BNE, BLT...
		op_jalr   = 7'b1100111, // Indirect jump.
		op_jal    = 7'b1101111  // Direct jump.
	} opcode_e;

	// ******************************
	// Control class
	// ******************************

	// What the predictor has to do.
	// Call and return are separate flags,
	// carried next to the class.
	typedef enum logic [1:0] {
		cls_none   = 2'd0, // Falls through.
		cls_jal    = 2'd1, // Always taken, target known.
		cls_jalr   = 2'd2, // Target from stack or execute.
		cls_branch = 2'd3  // Static direction.
	} ctrl_class_e;

endpackage

// ==== source/bp_stats_pkg.sv ====
// ******************************
// Status-side types for the APB block.
// ******************************
package bp_stats_pkg;

	// Decoded APB register select.
	typedef enum logic [2:0] {
		reg_branch  = 3'd0, // Branches queued.
		reg_mispred = 3'd1, // Mispredicts.
		reg_stall   = 3'd2, // Stall cycles.
		reg_ctrl    = 3'd3, // Write clears counters.
		reg_bad     = 3'd4  // Outside the map.
	} stat_reg_e;

endpackage

// ==== source/bp_if.sv ====
// ******************************
// Decoded fields, predecode to predictor.
// Fields are meaningful only with valid.
// ******************************
`include "bp_consts.svh"

interface predecode_if;
	import bp_inst_pkg::*;

	logic                valid;     // Slot holds an instruction.
	ctrl_class_e         cls;       // Control class.
	logic                is_call;   // Link register written.
	logic                is_return; // Jump through link register.
	logic [`BP_XLEN-1:0] imm;       // Sign-extended immediate.
	logic [`BP_XLEN-1:0] pc;        // Instruction pc.

	// Producer side.
	modport decode (output valid, cls, is_call, is_return, imm, pc);

	// Consumer side.
	modport predict (input valid, cls, is_call, is_return, imm, pc);

endinterface

// ==== source/gen_fifo.sv ====
// ******************************
// Synchronous FIFO, depth 2**AW.
// Head readable without delay. Flush empties it.
// ******************************
module gen_fifo #(
	parameter int DW = 64,
	parameter int AW = 4
) (
	input  logic          CLK,
	input  logic          reset,
	input  logic          flush,
	input  logic          fifo_push,
	input  logic          fifo_pop,
	input  logic [DW-1:0] data_push,
	output logic [DW-1:0] data_pop,
	output logic          fifo_empty,
	output logic          fifo_full
);
	localparam int DEPTH = 1 << AW;

	logic [DW-1:0] mem [DEPTH];
	logic [AW:0]   rd_ptr; // Extra wrap bit on top.
	logic [AW:0]   wr_ptr;

	// Same index, different lap means full.
	assign fifo_empty = (rd_ptr == wr_ptr);
	assign fifo_full  = (rd_ptr[AW] != wr_ptr[AW]) && (rd_ptr[AW-1:0] == wr_ptr[AW-1:0]);
	assign data_pop   = mem[rd_ptr[AW-1:0]]; // Head, no delay.

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
		end else begin
			if (fifo_push) wr_ptr <= wr_ptr + 1'b1;
			if (fifo_pop)  rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (fifo_push) mem[wr_ptr[AW-1:0]] <= data_push;
	end

	// Producer must respect full unless a slot frees this cycle.
	a_no_overflow: assert property (@(posedge CLK) disable iff (reset || flush)
		!(fifo_push && fifo_full && !fifo_pop));

	// Consumer never pops an empty queue.
	a_no_underflow: assert property (@(posedge CLK) disable iff (reset || flush)
		!(fifo_pop && fifo_empty));

endmodule

// ==== source/gen_ring_stack.sv ====
// ******************************
// LIFO over a ring of 2**AW entries.
// Push when full drops the oldest entry.
// ******************************
module gen_ring_stack #(
	parameter int DW = 64,
	parameter int AW = 4
) (
	input  logic          CLK,
	input  logic          reset,
	input  logic          flush,
	input  logic          stack_push,
	input  logic          stack_pop,
	input  logic [DW-1:0] data_push,
	output logic [DW-1:0] data_pop,
	output logic          stack_empty
);
	localparam int DEPTH = 1 << AW;

	logic [DW-1:0] mem [DEPTH];
	logic [AW-1:0] sp;    // Next free slot.
	logic [AW-1:0] top;   // Current top entry.
	logic [AW:0]   count; // Saturates at DEPTH.

	assign top         = sp - 1'b1;
	assign data_pop    = mem[top]; // Top, no delay.
	assign stack_empty = (count == '0);

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			sp    <= '0;
			count <= '0;
		end else if (stack_push && !stack_pop) begin
			sp <= sp + 1'b1; // Wraps over the oldest.
			if (count != (AW+1)'(DEPTH)) count <= count + 1'b1;
		end else if (stack_pop && !stack_push) begin
			sp    <= top;
			count <= count - 1'b1;
		end
		// Push with pop replaces the top in place.
	end

	always_ff @(posedge CLK) begin
		if (stack_push) mem[stack_pop ? top : sp] <= data_push;
	end

	// Predictor only pops a non-empty stack.
	a_no_pop_empty: assert property (@(posedge CLK) disable iff (reset || flush)
		!(stack_pop && stack_empty));

endmodule

// ==== source/predecode.sv ====
// ******************************
// Stage one. Registers and classifies.
// Holds its slot while stall is high.
// ******************************
`include "bp_consts.svh"

module predecode (
	input  logic                CLK,
	input  logic                reset,
	input  logic                flush,
	input  logic                inst_valid,
	input  logic [31:0]         inst,
	input  logic [`BP_XLEN-1:0] inst_pc,
	input  logic                stall,
	output logic                inst_ready,
	predecode_if.decode         dec
);
	import bp_inst_pkg::*;

	opcode_e             opcode;
	ctrl_class_e         cls_d;
	logic [`BP_XLEN-1:0] imm_d;
	logic                rd_link;  // rd is x1 or x5.
	logic                rs1_link; // rs1 is x1 or x5.
	logic                rd_zero;

	assign inst_ready = ~stall;

	// ******************************
	// Decode
	// ******************************
	always_comb begin
		case (inst[6:0]) // RVC low bits never match here.
			op_jal:    opcode = op_jal;
			op_jalr:   opcode = op_jalr;
			op_branch: opcode = op_branch;
			default:   opcode = op_other;
		endcase
	end

	assign rd_link  = (inst[11:7] == 5'd1) || (inst[11:7] == 5'd5);
	assign rs1_link = (inst[19:15] == 5'd1) || (inst[19:15] == 5'd5);
	assign rd_zero  = (inst[11:7] == 5'd0);

	always_comb begin
		cls_d = cls_none;
		imm_d = '0;
		case (opcode)
			op_jal: begin
				cls_d = cls_jal; // J-type.
				imm_d = {{(`BP_XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			op_jalr: begin
				cls_d = cls_jalr; // I-type.
				imm_d = {{(`BP_XLEN-12){inst[31]}}, inst[31:20]};
			end
			op_branch: begin
				cls_d = cls_branch; // B-type.
				imm_d = {{(`BP_XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			default: ;
		endcase
	end

	// ******************************
	// Pipeline register
	// ******************************
	always_ff @(posedge CLK) begin
		if (reset || flush) dec.valid <= 1'b0;
		else if (!stall)    dec.valid <= inst_valid; // Bubble if none offered.
	end

	always_ff @(posedge CLK) begin
		if (inst_valid && !stall) begin
			dec.cls       <= cls_d;
			dec.imm       <= imm_d;
			dec.pc        <= inst_pc;
			dec.is_call   <= ((opcode == op_jal) || (opcode == op_jalr)) && rd_link;
			dec.is_return <= (opcode == op_jalr) && rs1_link && rd_zero;
		end
	end

endmodule

// ==== source/branch_predict.sv ====
// ******************************
// Stage two. Static direction, return stack.
// Execute resolves branches and JALRs in order.
// ******************************
`include "bp_consts.svh"

module branch_predict (
	input  logic                CLK,
	input  logic                reset,
	input  logic                flush,
	predecode_if.predict        dec,
	input  logic                jalr_valid,
	input  logic [`BP_XLEN-1:0] jalr_pc,
	input  logic                bru_res_valid,
	input  logic                bru_taken,
	output logic                branch_pc_valid,
	output logic [`BP_XLEN-1:0] branch_pc,
	output logic                mispredict,
	output logic                stall,
	output logic                branch_push
);
	import bp_inst_pkg::*;

	logic                is_jal, is_jalr, is_branch;
	logic                go;             // Slot retires this cycle.
	logic [`BP_XLEN-1:0] next_pc;        // Fall-through.
	logic [`BP_XLEN-1:0] target_pc;      // pc + imm.
	logic                pred_back;      // Backward branch.
	logic                pred_taken;     // Taken redirect.
	logic [`BP_XLEN:0]   bht_data_push;  // {taken, other path}.
	logic [`BP_XLEN:0]   bht_data_pop;
	logic                bht_full;
	logic [`BP_XLEN-1:0] ras_top;
	logic                ras_push, ras_pop, ras_empty;
	logic                jalr_empty;     // No predicted return pending.
	logic                jalr_last;      // Unpredicted JALR resolved.
	logic                jalr_front;     // Predicted return executed.

	assign is_jal    = dec.valid && (dec.cls == cls_jal);
	assign is_jalr   = dec.valid && (dec.cls == cls_jalr);
	assign is_branch = dec.valid && (dec.cls == cls_branch);

	assign next_pc   = dec.pc + `BP_XLEN'(4);
	assign target_pc = dec.pc + dec.imm;
	assign pred_back = dec.imm[`BP_XLEN-1];

	// ******************************
	// Stall and acceptance
	// ******************************
	assign jalr_last  = jalr_valid && jalr_empty;
	assign jalr_front = jalr_valid && !jalr_empty;

	// Unpredictable JALR waits for execute; full queue blocks branches.
	assign stall = (is_jalr && !(dec.is_return && !ras_empty) && !jalr_last)
		|| (is_branch && bht_full);

	assign go = !stall && !mispredict && !flush; // Wrong path otherwise.

	assign ras_push    = go && dec.is_call && (is_jal || is_jalr);
	assign ras_pop     = go && is_jalr && dec.is_return && !ras_empty;
	assign branch_push = go && is_branch;
	assign pred_taken  = go && ((is_branch && pred_back) || is_jal || ras_pop);

	// Queue the guess and the path not taken.
	assign bht_data_push = {pred_back, pred_back ? next_pc : target_pc};

	assign mispredict = bru_res_valid && (bru_taken != bht_data_pop[`BP_XLEN]);

	// ******************************
	// Redirect
	// ******************************
	assign branch_pc_valid = mispredict || pred_taken || jalr_last;

	always_comb begin
		if (mispredict)   branch_pc = bht_data_pop[`BP_XLEN-1:0];
		else if (jalr_last) branch_pc = jalr_pc;
		else if (ras_pop) branch_pc = ras_top;
		else              branch_pc = target_pc;
	end

	gen_fifo #(.DW(`BP_XLEN+1), .AW(`BP_BHT_AW)) bht (
		.CLK(CLK), .reset(reset), .flush(flush || mispredict),
		.fifo_push(branch_push), .fifo_pop(bru_res_valid),
		.data_push(bht_data_push), .data_pop(bht_data_pop),
		.fifo_empty(), .fifo_full(bht_full)
	);

	gen_ring_stack #(.DW(`BP_XLEN), .AW(`BP_RAS_AW)) ras (
		.CLK(CLK), .reset(reset), .flush(flush),
		.stack_push(ras_push), .stack_pop(ras_pop),
		.data_push(next_pc), .data_pop(ras_top),
		.stack_empty(ras_empty)
	);

	// Counts returns predicted but not yet executed.
	gen_fifo #(.DW(1), .AW(`BP_RAS_AW)) ras_cnt (
		.CLK(CLK), .reset(reset), .flush(flush),
		.fifo_push(ras_pop), .fifo_pop(jalr_front),
		.data_push(1'b0), .data_pop(),
		.fifo_empty(jalr_empty), .fifo_full()
	);

	// One redirect source per cycle.
	a_one_redirect: assert property (@(posedge CLK) disable iff (reset)
		$onehot0({mispredict, pred_taken, jalr_last}));

endmodule

// ==== source/bp_stats_apb.sv ====
// ******************************
// Stage three. Event counters on APB.
// Counters saturate. Any write to CTRL clears.
// ******************************
`include "bp_consts.svh"

module bp_stats_apb (
	input  logic        CLK,
	input  logic        reset,
	input  logic        branch_push,
	input  logic        mispredict,
	input  logic        stall,
	input  logic [3:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);
	import bp_stats_pkg::*;

	stat_reg_e   sel;
	logic        access; // APB access phase.
	logic        clear;
	logic [31:0] cnt_branch, cnt_mispred, cnt_stall;

	function automatic logic [31:0] sat_inc(input logic [31:0] v);
		return (v == '1) ? v : v + 32'd1; // Stick at max.
	endfunction

	always_comb begin
		case (paddr)
			`BP_REG_BRANCH:  sel = reg_branch;
			`BP_REG_MISPRED: sel = reg_mispred;
			`BP_REG_STALL:   sel = reg_stall;
			`BP_REG_CTRL:    sel = reg_ctrl;
			default:         sel = reg_bad;
		endcase
	end

	assign access  = psel && penable;
	assign clear   = access && pwrite && (sel == reg_ctrl); // Value ignored.
	assign pready  = 1'b1; // Zero wait states.
	assign pslverr = access && ((sel == reg_bad) || (pwrite && (sel != reg_ctrl)));

	always_comb begin
		prdata = '0;
		if (access && !pwrite) begin
			case (sel)
				reg_branch:  prdata = cnt_branch;
				reg_mispred: prdata = cnt_mispred;
				reg_stall:   prdata = cnt_stall;
				default:     prdata = '0; // CTRL reads zero.
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (reset || clear) begin
			cnt_branch  <= '0;
			cnt_mispred <= '0;
			cnt_stall   <= '0;
		end else begin
			if (branch_push) cnt_branch  <= sat_inc(cnt_branch);
			if (mispredict)  cnt_mispred <= sat_inc(cnt_mispred);
			if (stall)       cnt_stall   <= sat_inc(cnt_stall);
		end
	end

	// Access phase always follows a setup phase.
	a_apb_setup: assert property (@(posedge CLK) disable iff (reset)
		$rose(penable) |-> psel && $past(psel) && !$past(penable));

endmodule

// ==== source/frontend_top.sv ====
// ******************************
// Branch prediction front end.
// Instances and wires only.
// ******************************
`include "bp_consts.svh"

module frontend_top (
	input  logic                CLK,
	input  logic                reset,
	input  logic                flush,
	input  logic                inst_valid,
	input  logic [31:0]         inst,
	input  logic [`BP_XLEN-1:0] inst_pc,
	output logic                inst_ready,
	input  logic                jalr_valid,
	input  logic [`BP_XLEN-1:0] jalr_pc,
	input  logic                bru_res_valid,
	input  logic                bru_taken,
	output logic                branch_pc_valid,
	output logic [`BP_XLEN-1:0] branch_pc,
	output logic                mispredict,
	input  logic [3:0]          paddr,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  logic [31:0]         pwdata,
	output logic [31:0]         prdata,
	output logic                pready,
	output logic                pslverr
);
	logic stall;       // Back-pressure into predecode.
	logic branch_push; // Branch queued, for stats.

	predecode_if pd_if ();

	// Mispredict squashes the slot like a flush.
	predecode u_predecode (
		.CLK(CLK), .reset(reset), .flush(flush || mispredict),
		.inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc),
		.stall(stall), .inst_ready(inst_ready), .dec(pd_if.decode)
	);

	branch_predict u_branch_predict (
		.CLK(CLK), .reset(reset), .flush(flush), .dec(pd_if.predict),
		.jalr_valid(jalr_valid), .jalr_pc(jalr_pc),
		.bru_res_valid(bru_res_valid), .bru_taken(bru_taken),
		.branch_pc_valid(branch_pc_valid), .branch_pc(branch_pc),
		.mispredict(mispredict), .stall(stall), .branch_push(branch_push)
	);

	bp_stats_apb u_stats (
		.CLK(CLK), .reset(reset), .branch_push(branch_push),
		.mispredict(mispredict), .stall(stall),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

endmodule

// ==== bench/tb_frontend.sv ====
// ******************************
// Testbench for frontend_top. Plays fetch and execute.
// Assertions compare ports with a model every cycle.
// ******************************
`include "bp_consts.svh"

module tb_frontend;
	timeunit 1ns;
	timeprecision 100ps;

	logic        CLK = 1'b0;
	logic        reset, flush, inst_valid, jalr_valid, bru_res_valid, bru_taken;
	logic [31:0] inst, pwdata, prdata;
	logic [63:0] inst_pc, jalr_pc, branch_pc;
	logic        inst_ready, branch_pc_valid, mispredict;
	logic [3:0]  paddr;
	logic        psel, penable, pwrite, pready, pslverr;

	// ******************************
	// Model state
	// ******************************
	integer      seed = 32'h74a4;
	string       test_name = "reset";
	int          errors = 0;
	int          timeouts = 0;
	int          nbranch = 0, nmis = 0, nstall = 0;
	logic [64:0] pq[$]; // {predicted taken, other path}.
	logic [63:0] rs[$]; // Return addresses.
	logic        exp_redirect = 0, exp_mis = 0, exp_ready = 1;
	logic [63:0] exp_pc = '0;
	logic        apb_chk = 0, exp_slverr = 0;
	logic [31:0] exp_prdata = '0;

	frontend_top dut (.*);

	always #5 CLK = ~CLK;

	// ******************************
	// Checks
	// ******************************
	function automatic void report_value(input string what, input logic [63:0] exp,
			input logic [63:0] act);
		errors++;
		$display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
	endfunction

	a_redirect: assert property (@(posedge CLK) disable iff (reset)
		branch_pc_valid == exp_redirect)
		else report_value("branch_pc_valid", $sampled(exp_redirect), $sampled(branch_pc_valid));
	a_target: assert property (@(posedge CLK) disable iff (reset)
		exp_redirect |-> branch_pc == exp_pc)
		else report_value("branch_pc", $sampled(exp_pc), $sampled(branch_pc));
	a_mispredict: assert property (@(posedge CLK) disable iff (reset)
		mispredict == exp_mis)
		else report_value("mispredict", $sampled(exp_mis), $sampled(mispredict));
	a_ready: assert property (@(posedge CLK) disable iff (reset)
		inst_ready == exp_ready)
		else report_value("inst_ready", $sampled(exp_ready), $sampled(inst_ready));
	a_slverr: assert property (@(posedge CLK) disable iff (reset)
		apb_chk |-> (pslverr == exp_slverr) && pready)
		else report_value("pslverr", $sampled(exp_slverr), $sampled(pslverr));
	a_prdata: assert property (@(posedge CLK) disable iff (reset)
		(apb_chk && !pwrite) |-> prdata == exp_prdata)
		else report_value("prdata", $sampled(exp_prdata), $sampled(prdata));

	// ******************************
	// Encoders and helpers
	// ******************************
	function automatic logic [31:0] enc_branch(input logic [12:0] imm);
		return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
		return {12'd0, rs1, 3'b000, rd, 7'b1100111}; // Zero offset.
	endfunction

	function automatic logic [63:0] rand_pc();
		logic [31:0] hi, lo;
		hi = $random(seed);
		lo = $random(seed);
		return {hi, lo[31:2], 2'b00};
	endfunction

	// One clock. Expectations last for exactly one sample.
	task automatic tick();
		@(posedge CLK);
		if (!exp_ready && !reset) nstall++;
		#1;
		exp_redirect = 0;
		exp_mis = 0;
		exp_ready = 1;
		apb_chk = 0;
		jalr_valid = 0;
		bru_res_valid = 0;
	endtask

	// Offer one instruction until accepted. Ends in the decode cycle.
	task automatic send(input logic [31:0] w, input logic [63:0] pc);
		int n;
		n = 0;
		inst_valid = 1;
		inst = w;
		inst_pc = pc;
		while (!inst_ready && n < 50) begin
			tick();
			n++;
		end
		if (n >= 50) begin
			timeouts++;
			$display("%s: instruction never accepted", test_name);
		end
		tick();
		inst_valid = 0;
	endtask

	task automatic flush_front();
		flush = 1;
		tick();
		flush = 0;
		pq.delete();
		rs.delete();
	endtask

	task automatic predict_branch(input logic back);
		int          r;
		logic [12:0] imm;
		logic [63:0] pc, off;
		r = $random(seed);
		imm = {back, r[10:0], 1'b0}; // Sign picks the direction.
		off = {{51{imm[12]}}, imm};
		pc = rand_pc();
		send(enc_branch(imm), pc);
		if (back) begin
			exp_redirect = 1;
			exp_pc = pc + off;
			pq.push_back({1'b1, pc + 64'd4});
		end else begin
			pq.push_back({1'b0, pc + off});
		end
		nbranch++;
		tick();
	endtask

	task automatic call_or_jump(input logic [4:0] rd);
		int          r;
		logic [20:0] imm;
		logic [63:0] pc;
		r = $random(seed);
		imm = {r[20:1], 1'b0};
		pc = rand_pc();
		send(enc_jal(rd, imm), pc);
		exp_redirect = 1;
		exp_pc = pc + {{43{imm[20]}}, imm};
		if (rd == 5'd1) rs.push_back(pc + 64'd4); // Call.
		tick();
	endtask

	task automatic return_from_stack();
		send(enc_jalr(5'd0, 5'd1), rand_pc());
		exp_redirect = 1;
		exp_pc = rs.pop_back();
		tick();
	endtask

	// JALR with no prediction waits three cycles for execute.
	task automatic stalled_jalr(input logic [4:0] rs1);
		logic [63:0] jpc;
		jpc = rand_pc();
		send(enc_jalr(5'd0, rs1), rand_pc());
		repeat (3) begin
			exp_ready = 0;
			tick();
		end
		jalr_valid = 1;
		jalr_pc = jpc;
		exp_redirect = 1;
		exp_pc = jpc;
		tick();
	endtask

	task automatic resolve(input logic taken);
		logic [64:0] e;
		e = pq.pop_front();
		bru_res_valid = 1;
		bru_taken = taken;
		if (taken != e[64]) begin
			exp_mis = 1;
			exp_redirect = 1;
			exp_pc = e[63:0];
			pq.delete(); // Younger guesses are wrong path.
			nmis++;
		end
		tick();
	endtask

	task automatic apb_access(input logic wr, input logic [3:0] a, input logic [31:0] d,
			input logic err);
		paddr = a;
		pwrite = wr;
		pwdata = d;
		psel = 1;
		penable = 0;
		tick();
		penable = 1;
		apb_chk = 1;
		exp_prdata = d;
		exp_slverr = err;
		tick();
		psel = 0;
		penable = 0;
	endtask

	// ******************************
	// Stimulus
	// ******************************
	initial begin
		reset = 1;
		flush = 0;
		inst_valid = 0;
		inst = '0;
		inst_pc = '0;
		jalr_valid = 0;
		jalr_pc = '0;
		bru_res_valid = 0;
		bru_taken = 0;
		paddr = '0;
		psel = 0;
		penable = 0;
		pwrite = 0;
		pwdata = '0;
		repeat (3) @(posedge CLK);
		#1 reset = 0;
		tick();

		test_name = "static";
		predict_branch(1);
		predict_branch(0);
		call_or_jump(5'd0);
		resolve(1);
		resolve(0);

		test_name = "call_return";
		flush_front();
		repeat (3) call_or_jump(5'd1);
		repeat (3) return_from_stack();
		repeat (3) begin
			jalr_valid = 1; // Execute retires each predicted return.
			jalr_pc = rand_pc();
			tick();
		end
		stalled_jalr(5'd1); // Return with an empty stack.

		test_name = "mispredict";
		flush_front();
		predict_branch(1);
		predict_branch(0);
		predict_branch(0);
		resolve(1);
		resolve(1); // Guessed not taken.
		predict_branch(1); // Stale guess at the head would mispredict.
		resolve(1);

		test_name = "backpressure";
		flush_front();
		repeat (16) predict_branch(0);
		begin
			logic [63:0] pc;
			pc = rand_pc();
			send(enc_branch(13'h040), pc);
			repeat (2) begin
				exp_ready = 0;
				tick();
			end
			exp_ready = 0; // Slot frees at the end of this cycle.
			resolve(0);
			pq.push_back({1'b0, pc + 64'h40});
			nbranch++;
			tick();
		end
		repeat (16) resolve(0);
		stalled_jalr(5'd6);

		test_name = "apb";
		apb_access(0, `BP_REG_BRANCH, nbranch, 0);
		apb_access(0, `BP_REG_MISPRED, nmis, 0);
		apb_access(0, `BP_REG_STALL, nstall, 0);
		apb_access(1, `BP_REG_CTRL, 32'hdead, 0);
		apb_access(0, `BP_REG_BRANCH, 0, 0);
		apb_access(0, `BP_REG_MISPRED, 0, 0);
		apb_access(0, `BP_REG_STALL, 0, 0);
		apb_access(1, `BP_REG_STALL, 32'h1, 1);
		apb_access(0, 4'h6, 0, 1); // Hole in the map.

		$display("errors: %0d  timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// Watchdog for the whole run.
	initial begin
		#200000;
		$display("run did not finish in time");
		$display("sim failed");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+include
source/bp_inst_pkg.sv
source/bp_stats_pkg.sv
source/bp_if.sv
source/gen_fifo.sv
source/gen_ring_stack.sv
source/predecode.sv
source/branch_predict.sv
source/bp_stats_apb.sv
source/frontend_top.sv
bench/tb_frontend.sv

// ==== Makefile ====
LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module tb_frontend -o sim_tb

run: build
	./obj_dir/sim_tb | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

lint:
	verilator --lint-only --timing -f project.f --top-module frontend_top

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
